/* noc_pkg.sv */
package noc_pkg;

	// one byte on the link
	typedef logic [7:0] byte_t;

	// node id, used for destination and source
	typedef logic [7:0] node_id_t;

	// device side data word
	typedef logic [63:0] word_t;

	// data length in bytes, 1 to 128
	typedef logic [7:0] len_t;

	// queued write response
	// byte 0 command, byte 1 dest, byte 2 src, byte 3 accepted length
	typedef logic [31:0] wresp_t;

	// header command field, bits 2:0
	typedef enum logic [2:0] {
		cmd_nop = 3'd0,
		cmd_read = 3'd1,
		cmd_write = 3'd2,
		cmd_read_resp = 3'd3,
		cmd_write_resp = 3'd4,
		cmd_message = 3'd5,
		cmd_reserved_6 = 3'd6,
		cmd_reserved_7 = 3'd7
	} noc_cmd_e;

	// bytes per device word
	localparam int word_bytes = 8;

	// pushed words per firstin group
	localparam int frame_words = 25;

	// write response queue entries
	localparam int resp_fifo_depth = 4;

	// error code in bits 7:6 of the write response command
	localparam logic [1:0] err_dropped = 2'b01;

endpackage

/* resp_fifo.sv */
`timescale 1ns/1ps

module resp_fifo #(
	parameter int depth = noc_pkg::resp_fifo_depth
) (
	input logic clk,
	input logic reset,
	input logic push,
	input noc_pkg::wresp_t push_entry,
	input logic pop,
	output noc_pkg::wresp_t head,
	output logic empty,
	output logic full
);
	import noc_pkg::*;

	wresp_t mem [depth];
	logic [$clog2(depth)-1:0] wr_ptr;
	logic [$clog2(depth)-1:0] rd_ptr;
	logic [$clog2(depth+1)-1:0] count;
	logic do_push;
	logic do_pop;

	assign empty = count == '0;
	assign full = count == ($clog2(depth+1))'(depth);
	assign head = mem[rd_ptr];

	assign do_push = push && !full;
	assign do_pop = pop && !empty;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= (wr_ptr == ($clog2(depth))'(depth - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == ($clog2(depth))'(depth - 1)) ? '0 : rd_ptr + 1'b1;
			end
			// push and pop together leave the count alone
			if (do_push && !do_pop) begin
				count <= count + 1'b1;
			end else if (do_pop && !do_push) begin
				count <= count - 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr] <= push_entry;
		end
	end

endmodule

/* write_packer.sv */
`timescale 1ns/1ps

module write_packer (
	input logic clk,
	input logic reset,
	input logic data_valid,
	input noc_pkg::byte_t data_byte,
	input logic data_last,
	input logic packet_start,
	input logic stopin,
	output logic pushin,
	output logic firstin,
	output noc_pkg::word_t din,
	output noc_pkg::len_t acc_len,
	output logic drop_err
);
	import noc_pkg::*;

	// byte slot for the next data byte
	logic [$clog2(word_bytes)-1:0] byte_idx;
	word_t asm_r;
	word_t asm_next;
	logic word_done;

	// completed word waiting for its push cycle
	logic pend;
	logic [$clog2(word_bytes):0] pend_cnt;

	// position inside the firstin group
	logic [$clog2(frame_words)-1:0] word_cnt;

	len_t acc_r;
	logic err_r;

	// first byte of a word lands in bits 7:0, unused upper bytes stay zero
	always_comb begin
		asm_next = (byte_idx == '0) ? '0 : asm_r;
		asm_next[byte_idx*8 +: 8] = data_byte;
	end

	assign word_done = data_valid &&
		(byte_idx == ($clog2(word_bytes))'(word_bytes - 1) || data_last);

	// word is lost when the device is not ready in the push cycle
	assign pushin = pend && !stopin;
	assign firstin = pushin && word_cnt == '0;

	// include the word in flight so the totals are final right after data_last
	assign acc_len = acc_r + (pushin ? len_t'(pend_cnt) : '0);
	assign drop_err = err_r || (pend && stopin);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			byte_idx <= '0;
			pend <= 1'b0;
			pend_cnt <= '0;
			word_cnt <= '0;
			acc_r <= '0;
			err_r <= 1'b0;
		end else begin
			pend <= word_done;
			if (packet_start) begin
				byte_idx <= '0;
			end else if (word_done) begin
				byte_idx <= '0;
				pend_cnt <= {1'b0, byte_idx} + 1'b1;
			end else if (data_valid) begin
				byte_idx <= byte_idx + 1'b1;
			end
			// group count runs since reset, across packets
			if (pushin) begin
				if (word_cnt == ($clog2(frame_words))'(frame_words - 1)) begin
					word_cnt <= '0;
				end else begin
					word_cnt <= word_cnt + 1'b1;
				end
			end
			if (packet_start) begin
				acc_r <= '0;
				err_r <= 1'b0;
			end else begin
				acc_r <= acc_len;
				err_r <= drop_err;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (data_valid) begin
			asm_r <= asm_next;
		end
		if (word_done) begin
			din <= asm_next;
		end
	end

endmodule

/* noc_control.sv */
`timescale 1ns/1ps

module noc_control (
	input logic clk,
	input logic reset,
	input logic tod_ctl,
	input noc_pkg::byte_t tod_data,
	// byte stream to the packer
	output logic data_valid,
	output noc_pkg::byte_t data_byte,
	output logic data_last,
	output logic packet_start,
	input noc_pkg::len_t acc_len,
	input logic drop_err,
	// write response queue
	output logic push,
	output noc_pkg::wresp_t push_entry,
	input logic full,
	// pending read
	output logic rd_valid,
	input logic rd_ready,
	output noc_pkg::node_id_t rd_dest,
	output noc_pkg::node_id_t rd_src,
	output noc_pkg::len_t rd_dlen
);
	import noc_pkg::*;

	typedef enum logic [2:0] {
		st_idle,
		st_dest,
		st_src,
		st_addr,
		st_data
	} ctl_state_e;

	ctl_state_e state;

	// header fields, only meaningful while tod_ctl is high
	noc_cmd_e hdr_cmd;
	logic [1:0] hdr_alen;
	logic [2:0] hdr_dlen;
	logic hdr_take;

	// per packet context
	logic is_write;
	logic [2:0] addr_top;
	logic [2:0] addr_cnt;
	len_t dlen;
	len_t data_cnt;
	node_id_t dest_r;
	node_id_t src_r;

	// end of address phase of a read
	logic rd_set;
	// last data byte was taken last cycle
	logic wr_done;
	byte_t resp_cmd;

	assign hdr_cmd = noc_cmd_e'(tod_data[2:0]);
	assign hdr_alen = tod_data[7:6];
	assign hdr_dlen = tod_data[5:3];

	// read header is dropped while the previous read still waits
	assign hdr_take = tod_ctl &&
		(hdr_cmd == cmd_write || (hdr_cmd == cmd_read && !rd_valid));

	assign packet_start = tod_ctl && hdr_cmd == cmd_write;

	assign data_valid = state == st_data && !tod_ctl;
	assign data_byte = tod_data;
	assign data_last = data_valid && data_cnt == len_t'(dlen - 8'd1);

	assign rd_set = state == st_addr && !tod_ctl && addr_cnt == addr_top && !is_write;

	// response goes out one cycle after the last byte, lost when the queue is full
	assign push = wr_done && !full;
	assign resp_cmd = {drop_err ? err_dropped : 2'b00, 3'b000, cmd_write_resp};
	assign push_entry = {acc_len, src_r, dest_r, resp_cmd};

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= st_idle;
			is_write <= 1'b0;
			addr_top <= '0;
			addr_cnt <= '0;
			dlen <= '0;
			data_cnt <= '0;
			wr_done <= 1'b0;
			rd_valid <= 1'b0;
		end else begin
			wr_done <= data_last;
			if (rd_valid && rd_ready) begin
				rd_valid <= 1'b0;
			end
			if (rd_set) begin
				rd_valid <= 1'b1;
			end
			if (tod_ctl) begin
				// any header abandons the packet in progress
				if (hdr_take) begin
					state <= st_dest;
					is_write <= hdr_cmd == cmd_write;
					addr_top <= 3'((4'd1 << hdr_alen) - 4'd1);
					dlen <= len_t'(8'd1 << hdr_dlen);
					addr_cnt <= '0;
					data_cnt <= '0;
				end else begin
					state <= st_idle;
				end
			end else begin
				case (state)
					st_dest: state <= st_src;
					st_src: state <= st_addr;
					st_addr: begin
						if (addr_cnt == addr_top) begin
							// reads carry no data bytes
							state <= is_write ? st_data : st_idle;
						end else begin
							addr_cnt <= addr_cnt + 3'd1;
						end
					end
					st_data: begin
						if (data_last) begin
							state <= st_idle;
						end else begin
							data_cnt <= data_cnt + 8'd1;
						end
					end
					default: state <= st_idle;
				endcase
			end
		end
	end

	// ids and the read request payload
	always_ff @(posedge clk) begin
		if (state == st_dest && !tod_ctl) begin
			dest_r <= tod_data;
		end
		if (state == st_src && !tod_ctl) begin
			src_r <= tod_data;
		end
		// held while rd_valid is up, since a new read cannot start then
		if (rd_set) begin
			rd_dest <= dest_r;
			rd_src <= src_r;
			rd_dlen <= dlen;
		end
	end

endmodule

/* resp_serializer.sv */
`timescale 1ns/1ps

module resp_serializer (
	input logic clk,
	input logic reset,
	// write response queue
	input logic empty,
	input noc_pkg::wresp_t head,
	output logic pop,
	// pending read
	input logic rd_valid,
	output logic rd_ready,
	input noc_pkg::node_id_t rd_dest,
	input noc_pkg::node_id_t rd_src,
	input noc_pkg::len_t rd_dlen,
	// device read side
	input logic pushout,
	input noc_pkg::word_t dout,
	output logic stopout,
	// outgoing link
	output logic frm_ctl,
	output noc_pkg::byte_t frm_data
);
	import noc_pkg::*;

	typedef enum logic [2:0] {
		s_idle,
		s_fetch,
		s_cmd,
		s_dest,
		s_src,
		s_len,
		s_data
	} ser_state_e;

	ser_state_e state;

	// current job
	logic job_rd;
	byte_t job_cmd;
	node_id_t job_dest;
	node_id_t job_src;
	len_t job_len;

	// read data path
	word_t word_r;
	len_t cnt;
	logic [$clog2(word_bytes)-1:0] bidx;
	logic take;
	logic more_words;
	logic fetch_next;

	// only start new jobs from idle, reads go first
	assign rd_ready = state == s_idle;
	assign pop = state == s_idle && !rd_valid && !empty;

	assign take = !stopout && pushout;
	assign bidx = cnt[$clog2(word_bytes)-1:0];

	// bytes left after the current word
	assign more_words = ({1'b0, cnt} + 9'd2) < {1'b0, job_len};
	// ask one cycle early so the word is taken with the last byte
	assign fetch_next = state == s_data &&
		bidx == ($clog2(word_bytes))'(word_bytes - 2) && more_words;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= s_idle;
			job_rd <= 1'b0;
			cnt <= '0;
			stopout <= 1'b1;
			frm_ctl <= 1'b1;
			frm_data <= '0;
		end else begin
			if (take) begin
				stopout <= 1'b1;
			end else if ((rd_valid && rd_ready) || fetch_next) begin
				stopout <= 1'b0;
			end
			case (state)
				s_idle: begin
					frm_ctl <= 1'b1;
					frm_data <= '0;
					cnt <= '0;
					if (rd_valid) begin
						job_rd <= 1'b1;
						state <= s_fetch;
					end else if (!empty) begin
						job_rd <= 1'b0;
						state <= s_cmd;
					end
				end
				s_fetch: begin
					// link stays idle until the first word is here
					if (take) begin
						state <= s_cmd;
					end
				end
				s_cmd: begin
					frm_ctl <= 1'b1;
					frm_data <= job_cmd;
					state <= s_dest;
				end
				s_dest: begin
					frm_ctl <= 1'b0;
					frm_data <= job_dest;
					state <= s_src;
				end
				s_src: begin
					frm_data <= job_src;
					state <= s_len;
				end
				s_len: begin
					frm_data <= job_len;
					// write response ends with its length byte
					state <= job_rd ? s_data : s_idle;
				end
				s_data: begin
					// low byte first
					frm_data <= word_r[bidx*8 +: 8];
					if (cnt == len_t'(job_len - 8'd1)) begin
						state <= s_idle;
					end else begin
						cnt <= cnt + 8'd1;
					end
				end
				default: state <= s_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rd_valid && rd_ready) begin
			job_cmd <= {5'b00000, cmd_read_resp};
			job_dest <= rd_dest;
			job_src <= rd_src;
			job_len <= rd_dlen;
		end else if (pop) begin
			job_cmd <= head[7:0];
			job_dest <= head[15:8];
			job_src <= head[23:16];
			job_len <= head[31:24];
		end
		if (take) begin
			word_r <= dout;
		end
	end

endmodule

/* noc_intf.sv */
`timescale 1ns/1ps

module noc_intf (
	input logic clk,
	input logic reset,
	// incoming link
	input logic tod_ctl,
	input noc_pkg::byte_t tod_data,
	// outgoing link
	output logic frm_ctl,
	output noc_pkg::byte_t frm_data,
	// device write side
	output logic pushin,
	output logic firstin,
	output noc_pkg::word_t din,
	input logic stopin,
	// device read side
	input logic pushout,
	input noc_pkg::word_t dout,
	output logic stopout
);
	import noc_pkg::*;

	// control to packer
	logic data_valid;
	byte_t data_byte;
	logic data_last;
	logic packet_start;

	// packer back to control
	len_t acc_len;
	logic drop_err;

	// write response queue
	logic push;
	wresp_t push_entry;
	logic full;
	logic pop;
	wresp_t head;
	logic empty;

	// pending read hand-off
	logic rd_valid;
	logic rd_ready;
	node_id_t rd_dest;
	node_id_t rd_src;
	len_t rd_dlen;

	noc_control u_control (
		.clk(clk),
		.reset(reset),
		.tod_ctl(tod_ctl),
		.tod_data(tod_data),
		.data_valid(data_valid),
		.data_byte(data_byte),
		.data_last(data_last),
		.packet_start(packet_start),
		.acc_len(acc_len),
		.drop_err(drop_err),
		.push(push),
		.push_entry(push_entry),
		.full(full),
		.rd_valid(rd_valid),
		.rd_ready(rd_ready),
		.rd_dest(rd_dest),
		.rd_src(rd_src),
		.rd_dlen(rd_dlen)
	);

	write_packer u_packer (
		.clk(clk),
		.reset(reset),
		.data_valid(data_valid),
		.data_byte(data_byte),
		.data_last(data_last),
		.packet_start(packet_start),
		.stopin(stopin),
		.pushin(pushin),
		.firstin(firstin),
		.din(din),
		.acc_len(acc_len),
		.drop_err(drop_err)
	);

	resp_fifo u_fifo (
		.clk(clk),
		.reset(reset),
		.push(push),
		.push_entry(push_entry),
		.pop(pop),
		.head(head),
		.empty(empty),
		.full(full)
	);

	resp_serializer u_serializer (
		.clk(clk),
		.reset(reset),
		.empty(empty),
		.head(head),
		.pop(pop),
		.rd_valid(rd_valid),
		.rd_ready(rd_ready),
		.rd_dest(rd_dest),
		.rd_src(rd_src),
		.rd_dlen(rd_dlen),
		.pushout(pushout),
		.dout(dout),
		.stopout(stopout),
		.frm_ctl(frm_ctl),
		.frm_data(frm_data)
	);

endmodule

/* noc_intf_assertions.sv */
`timescale 1ns/1ps

module noc_intf_assertions (
	input logic clk,
	input logic reset,
	input logic pushin,
	input logic stopin,
	input logic firstin,
	input logic pushout,
	input logic stopout,
	input logic frm_ctl,
	input logic data_last,
	input logic full
);

	int fail_count = 0;

	// device not ready means no push
	a_push_stop: assert property (@(posedge clk) disable iff (reset) !(pushin && stopin))
		else begin
			$error("pushin high while stopin is high");
			fail_count++;
		end

	a_first_push: assert property (@(posedge clk) disable iff (reset) firstin |-> pushin)
		else begin
			$error("firstin high without pushin");
			fail_count++;
		end

	// mid-response fetch, the link cannot wait for the device
	a_word_ready: assert property (@(posedge clk) disable iff (reset)
		(!stopout && !frm_ctl) |-> pushout)
		else begin
			$error("no pushout while stopout is low during a read response");
			fail_count++;
		end

	// response queued the cycle after the last data byte
	a_queue_room: assert property (@(posedge clk) disable iff (reset) data_last |=> !full)
		else begin
			$error("write response lost, response queue full");
			fail_count++;
		end

endmodule

bind noc_intf noc_intf_assertions u_assertions (
	.clk(clk),
	.reset(reset),
	.pushin(pushin),
	.stopin(stopin),
	.firstin(firstin),
	.pushout(pushout),
	.stopout(stopout),
	.frm_ctl(frm_ctl),
	.data_last(data_last),
	.full(full)
);

/* noc_intf_tb.sv */
`timescale 1ns/1ps

module noc_intf_tb;
	import noc_pkg::*;

	localparam int n_rows = 10;
	// marks an unused drop or order column
	localparam logic [7:0] none_idx = 8'hff;

	// one packet per row
	// drop is the data word index held off by stopin
	// order is the position of the response on the outgoing link
	typedef struct packed {
		noc_cmd_e cmd;
		logic [1:0] acode;
		logic [2:0] dcode;
		byte_t dest;
		byte_t src;
		logic [7:0] drop;
		logic [7:0] order;
		logic [7:0] gap;
	} row_t;

	row_t rows [n_rows] = '{
		'{cmd_write, 2'd0, 3'd4, 8'h11, 8'h21, none_idx, 8'd0, 8'd20},
		'{cmd_write, 2'd1, 3'd1, 8'h12, 8'h22, none_idx, 8'd1, 8'd20},
		'{cmd_write, 2'd0, 3'd5, 8'h13, 8'h23, 8'd1, 8'd2, 8'd20},
		'{cmd_message, 2'd0, 3'd1, 8'h14, 8'h24, none_idx, none_idx, 8'd4},
		// read, short write, read back to back
		// second read goes out ahead of the queued write response
		'{cmd_read, 2'd0, 3'd4, 8'h15, 8'h25, none_idx, 8'd3, 8'd0},
		'{cmd_write, 2'd0, 3'd0, 8'h16, 8'h26, none_idx, 8'd5, 8'd0},
		'{cmd_read, 2'd0, 3'd3, 8'h17, 8'h27, none_idx, 8'd4, 8'd40},
		'{cmd_write, 2'd2, 3'd7, 8'h18, 8'h28, none_idx, 8'd6, 8'd30},
		'{cmd_write, 2'd3, 3'd7, 8'h19, 8'h29, 8'd3, 8'd7, 8'd30},
		'{cmd_read, 2'd1, 3'd0, 8'h1a, 8'h2a, none_idx, 8'd8, 8'd20}
	};

	logic clk;
	logic reset;
	logic tod_ctl;
	byte_t tod_data;
	logic frm_ctl;
	byte_t frm_data;
	logic pushin;
	logic firstin;
	word_t din;
	logic stopin;
	logic pushout;
	word_t dout;
	logic stopout;

	// expected responses, indexed by output order
	byte_t exp_cmd [n_rows];
	node_id_t exp_dest [n_rows];
	node_id_t exp_src [n_rows];
	len_t exp_len [n_rows];
	logic exp_rd [n_rows];
	int n_resp;
	int out_count;

	word_t exp_words [$];
	word_t rd_words [$];
	byte_t pkt_q [$];
	logic collecting;
	int pushed_count;

	int value_errors;
	int other_errors;
	int cycles;
	int cycle_limit;

	noc_intf dut0 (
		.clk(clk),
		.reset(reset),
		.tod_ctl(tod_ctl),
		.tod_data(tod_data),
		.frm_ctl(frm_ctl),
		.frm_data(frm_data),
		.pushin(pushin),
		.firstin(firstin),
		.din(din),
		.stopin(stopin),
		.pushout(pushout),
		.dout(dout),
		.stopout(stopout)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic check_value(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		if (got !== exp) begin
			$display("Fail at time %0t: %s is %h, expected %h", $time, name, got, exp);
			value_errors++;
		end
	endtask

	// link bytes in and out, twice over, plus slack
	function automatic int cycle_budget();
		int total;
		total = 0;
		for (int i = 0; i < n_rows; i++) begin
			total += 3 + (1 << rows[i].acode);
			if (rows[i].cmd != cmd_read) begin
				total += 1 << rows[i].dcode;
			end
			if (rows[i].order != none_idx) begin
				total += 4 + ((rows[i].cmd == cmd_read) ? (1 << rows[i].dcode) : 0);
			end
		end
		return 2 * total + 200;
	endfunction

	// drives one packet and predicts its words and response
	task automatic send_packet(input row_t r);
		int n_addr;
		int n_data;
		int w_bytes;
		int acc;
		logic dropped;
		logic stop_next;
		word_t w;
		byte_t b;
		n_addr = 1 << r.acode;
		n_data = (r.cmd == cmd_read) ? 0 : (1 << r.dcode);
		w = '0;
		w_bytes = 0;
		acc = 0;
		dropped = 1'b0;
		stop_next = 1'b0;
		@(posedge clk);
		tod_ctl <= 1'b1;
		tod_data <= {r.acode, r.dcode, r.cmd};
		stopin <= 1'b0;
		@(posedge clk);
		tod_ctl <= 1'b0;
		tod_data <= r.dest;
		@(posedge clk);
		tod_data <= r.src;
		for (int i = 0; i < n_addr; i++) begin
			@(posedge clk);
			tod_data <= byte_t'($urandom);
		end
		for (int i = 0; i < n_data; i++) begin
			@(posedge clk);
			b = byte_t'($urandom);
			tod_data <= b;
			// device busy in the push cycle of the chosen word
			stopin <= stop_next;
			stop_next = 1'b0;
			w[w_bytes*8 +: 8] = b;
			w_bytes++;
			if (w_bytes == word_bytes || i == n_data - 1) begin
				if (i / word_bytes == r.drop) begin
					stop_next = 1'b1;
					dropped = 1'b1;
				end else if (r.cmd == cmd_write) begin
					exp_words.push_back(w);
					acc += w_bytes;
				end
				w = '0;
				w_bytes = 0;
			end
		end
		// response can leave during the gap below
		if (r.order != none_idx) begin
			exp_dest[r.order] = r.dest;
			exp_src[r.order] = r.src;
			exp_rd[r.order] = r.cmd == cmd_read;
			if (r.cmd == cmd_read) begin
				exp_cmd[r.order] = 8'h03;
				exp_len[r.order] = len_t'(1 << r.dcode);
			end else begin
				exp_cmd[r.order] = dropped ? {err_dropped, 6'h04} : 8'h04;
				exp_len[r.order] = len_t'(acc);
			end
		end
		for (int g = 0; g < r.gap; g++) begin
			@(posedge clk);
			tod_ctl <= 1'b0;
			tod_data <= 8'h00;
			stopin <= (g == 0) ? stop_next : 1'b0;
		end
	endtask

	// compares a finished outgoing packet with the next expected one
	task automatic finish_packet();
		int n;
		int n_bytes;
		word_t w;
		n = out_count;
		out_count++;
		w = '0;
		if (n >= n_resp) begin
			$display("error: extra packet with command %h at %0t", pkt_q[0], $time);
			other_errors++;
			return;
		end
		n_bytes = exp_rd[n] ? 4 + int'(exp_len[n]) : 4;
		check_value("frm_data command", pkt_q[0], exp_cmd[n]);
		check_value("frm packet size", pkt_q.size(), n_bytes);
		if (pkt_q.size() != n_bytes) begin
			return;
		end
		check_value("frm_data dest", pkt_q[1], exp_dest[n]);
		check_value("frm_data src", pkt_q[2], exp_src[n]);
		check_value("frm_data length", pkt_q[3], exp_len[n]);
		for (int i = 4; i < n_bytes; i++) begin
			if ((i - 4) % word_bytes == 0) begin
				if (rd_words.size() == 0) begin
					$display("error: read data sent with no device word taken at %0t", $time);
					other_errors++;
					return;
				end
				w = rd_words.pop_front();
			end
			check_value("frm_data read byte", pkt_q[i], w[((i - 4) % word_bytes)*8 +: 8]);
		end
	endtask

	// outgoing link monitor
	always @(posedge clk) begin
		if (!reset) begin
			if (frm_ctl && frm_data != 8'h00) begin
				if (collecting) begin
					finish_packet();
				end
				pkt_q = {};
				pkt_q.push_back(frm_data);
				collecting = 1'b1;
			end else if (!frm_ctl) begin
				if (collecting) begin
					pkt_q.push_back(frm_data);
				end else begin
					$display("error: byte %h on the idle outgoing link at %0t", frm_data, $time);
					other_errors++;
				end
			end else if (collecting) begin
				finish_packet();
				collecting = 1'b0;
			end
		end
	end

	// write side device, records every pushed word
	always @(posedge clk) begin
		if (!reset && pushin) begin
			if (exp_words.size() == 0) begin
				$display("error: word %h pushed with none expected at %0t", din, $time);
				other_errors++;
			end else begin
				check_value("din", din, exp_words.pop_front());
			end
			check_value("firstin", firstin, (pushed_count % frame_words) == 0);
			pushed_count++;
		end
	end

	// read side device, always has a word on offer
	always @(posedge clk) begin
		if (reset) begin
			pushout <= 1'b0;
		end else begin
			if (pushout && !stopout) begin
				rd_words.push_back(dout);
			end
			if (!pushout || !stopout) begin
				dout <= {$urandom, $urandom};
			end
			pushout <= 1'b1;
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= cycle_limit) begin
			$display("timeout: run still busy after %0d cycles", cycles);
			$display("Finished with errors");
			$finish;
		end
	end

	initial begin
		void'($urandom(32'h9b0b));
		reset = 1'b1;
		tod_ctl = 1'b0;
		tod_data = 8'h00;
		stopin = 1'b0;
		pushout = 1'b0;
		dout = '0;
		collecting = 1'b0;
		out_count = 0;
		pushed_count = 0;
		value_errors = 0;
		other_errors = 0;
		cycles = 0;
		cycle_limit = cycle_budget();
		n_resp = 0;
		for (int i = 0; i < n_rows; i++) begin
			if (rows[i].order != none_idx) begin
				n_resp++;
			end
		end
		repeat (4) @(posedge clk);
		// reset values before release
		check_value("pushin", pushin, 1'b0);
		check_value("firstin", firstin, 1'b0);
		check_value("stopout", stopout, 1'b1);
		check_value("frm_ctl", frm_ctl, 1'b1);
		check_value("frm_data", frm_data, 8'h00);
		check_value("rd_valid", dut0.u_control.rd_valid, 1'b0);
		reset <= 1'b0;
		// idle link before the first header
		repeat (5) @(posedge clk);
		for (int i = 0; i < n_rows; i++) begin
			send_packet(rows[i]);
		end
		while (out_count < n_resp) begin
			@(posedge clk);
		end
		repeat (10) @(posedge clk);
		if (exp_words.size() != 0) begin
			$display("error: %0d expected device words never pushed", exp_words.size());
			other_errors++;
		end
		if (rd_words.size() != 0) begin
			$display("error: %0d device words taken but never sent", rd_words.size());
			other_errors++;
		end
		if (pushed_count <= frame_words) begin
			$display("error: only %0d words pushed, second firstin group not reached",
				pushed_count);
			other_errors++;
		end
		$display("value errors: %0d, other errors: %0d, assertion failures: %0d",
			value_errors, other_errors, dut0.u_assertions.fail_count);
		if (value_errors == 0 && other_errors == 0 && dut0.u_assertions.fail_count == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

/* files.f */
noc_pkg.sv
resp_fifo.sv
write_packer.sv
noc_control.sv
resp_serializer.sv
noc_intf.sv
noc_intf_assertions.sv
noc_intf_tb.sv

/* run.sh */
#!/bin/sh
# build and run the noc_intf testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module noc_intf_tb -f files.f -o noc_intf_sim

out=$(./obj_dir/noc_intf_sim)
echo "$out"

if echo "$out" | grep -qx "Finished with no errors"; then
	exit 0
else
	exit 1
fi
